// File: sources.f
rtl/lidar_pkg.sv
rtl/tdc_regs.sv
rtl/tdc_spi_master.sv
rtl/tdc_control.sv
rtl/sample_fifo.sv
rtl/uart_result_tx.sv
rtl/lidar_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
TOP       ?= tb_top
SEED      ?= 42
LOG       ?= sim.log
FILELIST  ?= sources.f
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: build
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/tb_top.sv
module tb_top;

  localparam int SPI_CLK_DIV = 4;
  localparam int BAUD_DIV    = 16;
  localparam int FIFO_ADDR_W = 3;

  // Run length for the timeout
  localparam int N_SHOTS      = 40 + 6 + 4 + 3;
  localparam int MAX_PERIOD   = 500;
  localparam int MODEL_DELAY  = 40;
  localparam int PAUSE_WINDOW = 3000;
  localparam int PER_SHOT     = MAX_PERIOD + MODEL_DELAY + 48 * SPI_CLK_DIV + 20 * BAUD_DIV;
  localparam int TIMEOUT_CYCLES = N_SHOTS * PER_SHOT + PAUSE_WINDOW + 2000;

  logic clk;
  logic rst;

  // DUT inputs start in their idle levels
  logic                wb_cyc   = 1'b0;
  logic                wb_stb   = 1'b0;
  logic                wb_we    = 1'b0;
  lidar_pkg::wb_addr_t wb_adr   = '0;
  lidar_pkg::wb_data_t wb_dat_w = '0;
  logic                tdc_intb = 1'b1;
  logic                tdc_dout = 1'b0;

  lidar_pkg::wb_data_t wb_dat_r;
  logic                wb_ack;
  logic                tdc_enable;
  logic                tdc_start_signal;
  logic                tdc_sck;
  logic                tdc_mosi;
  logic                tdc_cs;
  logic                serial_out;

  // TDC model state
  lidar_pkg::tdc_result_t model_result = '0;
  logic                   model_push   = 1'b0;
  logic                   cmd_valid    = 1'b0;
  lidar_pkg::uart_byte_t  cmd_byte     = '0;
  lidar_pkg::uart_byte_t  cmd_shift    = '0;
  logic [23:0]            frame        = '0;
  logic                   sck_q        = 1'b0;
  logic                   cs_q         = 1'b1;
  int                     delay_left   = 0;
  int                     rise_idx     = 0;

  // Checker hookup
  int   test_id   = 0;
  logic final_req = 1'b0;
  int   error_count;
  int   byte_count;
  int   shots_seen;
  int   pending;
  int   cycles = 0;

  tb_clock #(.RESET_CYCLES(8)) u_clock (.clk(clk), .rst(rst));

  lidar_top #(
    .SPI_CLK_DIV(SPI_CLK_DIV),
    .BAUD_DIV(BAUD_DIV),
    .FIFO_ADDR_W(FIFO_ADDR_W)
  ) uut (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .tdc_intb(tdc_intb), .tdc_dout(tdc_dout),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .tdc_enable(tdc_enable),
    .tdc_start_signal(tdc_start_signal), .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi), .tdc_cs(tdc_cs), .serial_out(serial_out)
  );

  tb_checker #(.BAUD_DIV(BAUD_DIV)) u_checker (
    .clk(clk), .rst(rst), .test_id(test_id),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .tdc_enable(tdc_enable), .start_signal(tdc_start_signal),
    .tdc_cs(tdc_cs), .serial_out(serial_out),
    .model_push(model_push), .model_result(model_result),
    .cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .final_req(final_req),
    .error_count(error_count), .byte_count(byte_count),
    .shots_seen(shots_seen), .pending(pending)
  );

  // TDC model, works off sampled SCK and CS
  always @(posedge clk) begin
    model_push <= 1'b0;
    cmd_valid  <= 1'b0;
    sck_q      <= tdc_sck;
    cs_q       <= tdc_cs;
    if (rst) begin
      tdc_intb   <= 1'b1;
      tdc_dout   <= 1'b0;
      delay_left <= 0;
      rise_idx   <= 0;
    end else begin
      // New shot: pick the result and the interrupt delay
      if (tdc_start_signal) begin
        model_result <= 16'($urandom);
        model_push   <= 1'b1;
        delay_left   <= 5 + int'($urandom % 36);
      end else if (delay_left > 0) begin
        delay_left <= delay_left - 1;
        if (delay_left == 1) begin
          tdc_intb <= 1'b0;
        end
      end
      // Frame is a dummy byte under the opcode, then the result
      if (cs_q && !tdc_cs) begin
        tdc_intb <= 1'b1;
        frame    <= {8'h00, model_result};
        rise_idx <= 0;
        tdc_dout <= 1'b0;
      end else if (!tdc_cs && !sck_q && tdc_sck) begin
        // DUT sampled at this rise, so the next bit goes out now
        if (rise_idx < 8) begin
          cmd_shift <= {cmd_shift[6:0], tdc_mosi};
        end
        if (rise_idx == 7) begin
          cmd_valid <= 1'b1;
          cmd_byte  <= {cmd_shift[6:0], tdc_mosi};
        end
        if (rise_idx < 23) begin
          tdc_dout <= frame[22-rise_idx];
        end
        rise_idx <= rise_idx + 1;
      end
    end
  end

  // One Wishbone classic access, held until ack
  task automatic bus_cycle(input logic we, input lidar_pkg::wb_addr_t adr,
                           input lidar_pkg::wb_data_t dat);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_ack && waited < 16);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wait_more_shots(input int n);
    int goal;
    goal = shots_seen + n;
    while (shots_seen < goal) @(posedge clk);
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    void'($urandom(42));
    while (rst) @(posedge clk);
    repeat (4) @(posedge clk);
    // Registers read back what was written
    test_id <= 1;
    bus_cycle(1'b1, lidar_pkg::REG_PERIOD, 16'd60);
    bus_cycle(1'b0, lidar_pkg::REG_PERIOD, 16'd0);
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0002);
    bus_cycle(1'b0, lidar_pkg::REG_CTRL, 16'd0);
    bus_cycle(1'b0, lidar_pkg::REG_SHOTS, 16'd0);
    // Enough shots at a short period to fill the FIFO
    test_id <= 2;
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0001);
    wait_more_shots(40);
    // Longer period, changed while paused
    test_id <= 3;
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0003);
    bus_cycle(1'b1, lidar_pkg::REG_PERIOD, MAX_PERIOD[15:0]);
    bus_cycle(1'b0, lidar_pkg::REG_PERIOD, 16'd0);
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0001);
    wait_more_shots(6);
    // Long quiet window under pause, then resume at another long period
    test_id <= 4;
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0003);
    repeat (PAUSE_WINDOW) @(posedge clk);
    bus_cycle(1'b1, lidar_pkg::REG_PERIOD, 16'd400);
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0001);
    wait_more_shots(4);
    // Count is stable once paused
    test_id <= 5;
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0003);
    bus_cycle(1'b0, lidar_pkg::REG_SHOTS, 16'd0);
    bus_cycle(1'b1, lidar_pkg::REG_CTRL, 16'h0000);
    // Drain the serial stream
    while (pending != 0) @(posedge clk);
    final_req <= 1'b1;
    @(posedge clk);
    final_req <= 1'b0;
    repeat (2) @(posedge clk);
    $display("Summary: errors %0d, bytes %0d, shots %0d", error_count, byte_count, shots_seen);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tests/tb_checker.sv
module tb_checker #(
  parameter int BAUD_DIV = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  int                     test_id,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  lidar_pkg::wb_addr_t    wb_adr,
  input  lidar_pkg::wb_data_t    wb_dat_w,
  input  lidar_pkg::wb_data_t    wb_dat_r,
  input  logic                   wb_ack,
  input  logic                   tdc_enable,
  input  logic                   start_signal,
  input  logic                   tdc_cs,
  input  logic                   serial_out,
  input  logic                   model_push,
  input  lidar_pkg::tdc_result_t model_result,
  input  logic                   cmd_valid,
  input  lidar_pkg::uart_byte_t  cmd_byte,
  input  logic                   final_req,
  output int                     error_count,
  output int                     byte_count,
  output int                     shots_seen,
  output int                     pending
);

  lidar_pkg::uart_byte_t   exp_q[$];
  lidar_pkg::uart_byte_t   rx_q[$];
  lidar_pkg::uart_byte_t   got;
  lidar_pkg::uart_byte_t   want;
  lidar_pkg::wb_data_t     reg_exp;
  lidar_pkg::shot_period_t period_sh = '0;
  logic en_sh    = 1'b0;
  logic pause_sh = 1'b0;
  logic rst_q    = 1'b0;
  logic ack_q    = 1'b0;
  logic start_q  = 1'b0;
  int   cycle     = 0;
  int   last_shot = -1;
  int   stall     = 0;
  int   mon_errs  = 0;
  int   cmp_errs  = 0;
  int   rx_errs   = 0;

  initial byte_count = 0;
  initial shots_seen = 0;
  initial pending    = 0;

  assign error_count = mon_errs + cmp_errs + rx_errs;

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "registers";
      2:       return "streaming";
      3:       return "spacing";
      4:       return "pause";
      default: return "shot_count";
    endcase
  endfunction

  // Byte n of the serial stream for one result, high byte first
  function automatic lidar_pkg::uart_byte_t stream_byte(input lidar_pkg::tdc_result_t r,
                                                        input int n);
    return (n == 0) ? r[15:8] : r[7:0];
  endfunction

  // Bus, shot and reset monitor
  always @(posedge clk) begin
    cycle++;
    rst_q   <= rst;
    ack_q   <= wb_ack;
    start_q <= start_signal;
    // Values right after a reset edge
    if (rst_q && (tdc_enable !== 1'b0 || start_signal !== 1'b0)) begin
      mon_errs++;
      $display("FAIL reset: enable/start expected 0/0 actual %b/%b", tdc_enable, start_signal);
    end
    if (rst_q && (tdc_cs !== 1'b1 || serial_out !== 1'b1)) begin
      mon_errs++;
      $display("FAIL reset: cs/serial_out expected 1/1 actual %b/%b", tdc_cs, serial_out);
    end
    if (rst) begin
      en_sh     = 1'b0;
      pause_sh  = 1'b0;
      period_sh = '0;
    end else begin
      if (wb_ack && ack_q) begin
        mon_errs++;
        $display("Wishbone ack stayed high for two cycles in test %s", test_name(test_id));
      end
      if (wb_ack && !(wb_cyc && wb_stb)) begin
        mon_errs++;
        $display("Wishbone ack came without an open bus cycle");
      end
      stall = (wb_cyc && wb_stb && !wb_ack) ? stall + 1 : 0;
      if (stall == 8) begin
        mon_errs++;
        $display("Wishbone access got no ack within 8 cycles");
      end
      // Writes update the expected register image, reads compare
      if (wb_ack && !ack_q && wb_we) begin
        if (wb_adr == lidar_pkg::REG_CTRL) begin
          en_sh    = wb_dat_w[0];
          pause_sh = wb_dat_w[1];
        end else if (wb_adr == lidar_pkg::REG_PERIOD) begin
          period_sh = wb_dat_w;
        end
      end else if (wb_ack && !ack_q) begin
        case (wb_adr)
          lidar_pkg::REG_CTRL:   reg_exp = {14'd0, pause_sh, en_sh};
          lidar_pkg::REG_PERIOD: reg_exp = period_sh;
          lidar_pkg::REG_SHOTS:  reg_exp = 16'(shots_seen);
          default:               reg_exp = '0;
        endcase
        if (wb_dat_r !== reg_exp) begin
          mon_errs++;
          $display("FAIL %s: register %0d expected %04h actual %04h",
                   test_name(test_id), wb_adr, reg_exp, wb_dat_r);
        end
      end
      // Enable pin follows the written control bit
      if (tdc_enable !== en_sh) begin
        mon_errs++;
        $display("FAIL %s: tdc_enable expected %b actual %b",
                 test_name(test_id), en_sh, tdc_enable);
      end
      if (start_signal && start_q) begin
        mon_errs++;
        $display("start_signal stayed high for more than one cycle");
      end
      if (start_signal && !start_q) begin
        // Shot decided before a control write took hold is allowed
        if ((!en_sh || pause_sh) && !(wb_ack && !ack_q)) begin
          mon_errs++;
          $display("Start pulse while shots were disabled or paused in test %s",
                   test_name(test_id));
        end
        if (last_shot >= 0 && cycle - last_shot < int'(period_sh)) begin
          mon_errs++;
          $display("FAIL %s: shot spacing expected >= %0d actual %0d",
                   test_name(test_id), period_sh, cycle - last_shot);
        end
        last_shot = cycle;
        shots_seen++;
      end
      if (cmd_valid && cmd_byte !== lidar_pkg::TDC_READ_CMD) begin
        mon_errs++;
        $display("FAIL %s: TDC command expected %02h actual %02h",
                 test_name(test_id), lidar_pkg::TDC_READ_CMD, cmd_byte);
      end
      if (final_req && byte_count != 2 * shots_seen) begin
        mon_errs++;
        $display("FAIL %s: byte count expected %0d actual %0d",
                 test_name(test_id), 2 * shots_seen, byte_count);
      end
    end
  end

  // UART receiver, samples each bit at its middle
  initial begin : uart_rx
    lidar_pkg::uart_byte_t data;
    int i;
    @(negedge rst);
    forever begin
      @(posedge clk);
      if (serial_out === 1'b0) begin
        repeat (BAUD_DIV / 2 - 1) @(posedge clk);
        if (serial_out !== 1'b0) begin
          rx_errs++;
          $display("Start bit on serial_out was shorter than half a bit");
        end else begin
          for (i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(posedge clk);
            data[i] = serial_out;
          end
          repeat (BAUD_DIV) @(posedge clk);
          if (serial_out !== 1'b1) begin
            rx_errs++;
            $display("Stop bit missing after byte %02h", data);
          end
          rx_q.push_back(data);
        end
      end
    end
  end

  // Stream order check against the model's results
  always @(posedge clk) begin
    if (model_push) begin
      exp_q.push_back(stream_byte(model_result, 0));
      exp_q.push_back(stream_byte(model_result, 1));
    end
    while (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      byte_count++;
      if (exp_q.size() == 0) begin
        cmp_errs++;
        $display("Byte %02h arrived on serial_out with no result pending", got);
      end else begin
        want = exp_q.pop_front();
        if (got !== want) begin
          cmp_errs++;
          $display("FAIL %s: serial byte expected %02h actual %02h",
                   test_name(test_id), want, got);
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  // Period of 10 time units
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held over the first rising edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: rtl/lidar_top.sv
module lidar_top #(
  parameter int SPI_CLK_DIV = 4,
  parameter int BAUD_DIV    = 16,
  parameter int FIFO_ADDR_W = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  lidar_pkg::wb_addr_t wb_adr,
  input  lidar_pkg::wb_data_t wb_dat_w,
  input  logic                tdc_intb,
  input  logic                tdc_dout,
  output lidar_pkg::wb_data_t wb_dat_r,
  output logic                wb_ack,
  output logic                tdc_enable,
  output logic                tdc_start_signal,
  output logic                tdc_sck,
  output logic                tdc_mosi,
  output logic                tdc_cs,
  output logic                serial_out
);

  // Register block to controller
  logic                    pause;
  logic                    shot_pulse;
  lidar_pkg::shot_period_t shot_period;

  // Controller to SPI master
  logic                  byte_start;
  logic                  last_byte;
  logic                  spi_busy;
  lidar_pkg::uart_byte_t tx_byte;
  lidar_pkg::uart_byte_t rx_byte;

  // Result path through the FIFO
  logic                   wr_en;
  logic                   rd_en;
  logic                   fifo_full;
  logic                   fifo_empty;
  lidar_pkg::tdc_result_t wr_data;
  lidar_pkg::tdc_result_t rd_data;

  tdc_regs u_regs (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .shot_pulse(shot_pulse),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    // Enable bit goes straight to the TDC pin
    .enable(tdc_enable), .pause(pause), .shot_period(shot_period)
  );

  tdc_control u_control (
    .clk(clk), .rst(rst),
    .enable(tdc_enable), .pause(pause), .tdc_intb(tdc_intb),
    .spi_busy(spi_busy), .fifo_full(fifo_full),
    .shot_period(shot_period), .rx_byte(rx_byte),
    .start_signal(tdc_start_signal), .shot_pulse(shot_pulse),
    .byte_start(byte_start), .last_byte(last_byte),
    .wr_en(wr_en), .tx_byte(tx_byte), .wr_data(wr_data)
  );

  tdc_spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) u_spi (
    .clk(clk), .rst(rst),
    .byte_start(byte_start), .last_byte(last_byte), .miso(tdc_dout),
    .tx_byte(tx_byte), .rx_byte(rx_byte), .busy(spi_busy),
    .sck(tdc_sck), .mosi(tdc_mosi), .cs(tdc_cs)
  );

  sample_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) u_fifo (
    .clk(clk), .rst(rst),
    .wr_en(wr_en), .rd_en(rd_en), .wr_data(wr_data),
    .rd_data(rd_data), .full(fifo_full), .empty(fifo_empty)
  );

  uart_result_tx #(.BAUD_DIV(BAUD_DIV)) u_uart (
    .clk(clk), .rst(rst),
    .empty(fifo_empty), .rd_data(rd_data),
    .rd_en(rd_en), .serial_out(serial_out)
  );

endmodule

// File: rtl/uart_result_tx.sv
module uart_result_tx #(
  parameter int BAUD_DIV = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   empty,
  input  lidar_pkg::tdc_result_t rd_data,
  output logic                   rd_en,
  output logic                   serial_out
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_POP,
    S_HIGH,
    S_LOW
  } state_t;

  state_t                state;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [3:0]            bit_idx;
  logic [8:0]            shreg;
  lidar_pkg::uart_byte_t lo_byte;
  logic                  baud_tick;
  logic                  byte_end;
  logic                  sending;

  assign rd_en     = (state == S_IDLE) && !empty;
  assign sending   = (state == S_HIGH) || (state == S_LOW);
  assign baud_tick = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
  // Bit 9 is the stop bit
  assign byte_end  = baud_tick && (bit_idx == 4'd9);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      serial_out <= 1'b1;
      baud_cnt   <= '0;
      bit_idx    <= '0;
    end else begin
      case (state)
        S_IDLE: if (!empty) state <= S_POP;
        // FIFO data valid now, start bit goes out
        S_POP: begin
          serial_out <= 1'b0;
          baud_cnt   <= '0;
          bit_idx    <= '0;
          state      <= S_HIGH;
        end
        S_HIGH, S_LOW: begin
          baud_cnt <= baud_tick ? '0 : baud_cnt + BAUD_W'(1);
          if (byte_end) begin
            bit_idx <= '0;
            if (state == S_HIGH) begin
              // Low byte follows straight after the stop bit
              serial_out <= 1'b0;
              state      <= S_LOW;
            end else begin
              state <= S_IDLE;
            end
          end else if (baud_tick) begin
            serial_out <= shreg[0];
            bit_idx    <= bit_idx + 4'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data bits LSB first, stop bit parked on top
  always_ff @(posedge clk) begin
    if (state == S_POP) begin
      shreg   <= {1'b1, rd_data[15:8]};
      lo_byte <= rd_data[7:0];
    end else if (sending && byte_end) begin
      shreg <= {1'b1, lo_byte};
    end else if (sending && baud_tick) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

// File: rtl/sample_fifo.sv
module sample_fifo #(
  parameter int FIFO_ADDR_W = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  lidar_pkg::tdc_result_t wr_data,
  output lidar_pkg::tdc_result_t rd_data,
  output logic                   full,
  output logic                   empty
);

  localparam int DEPTH = 1 << FIFO_ADDR_W;

  lidar_pkg::tdc_result_t mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  logic [FIFO_ADDR_W:0]   count;

  // One extra count bit tells full from empty
  assign full  = (count == (FIFO_ADDR_W + 1)'(DEPTH));
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // Neither neighbour may overrun or underrun the buffer
  assert property (@(posedge clk) disable iff (rst) !(wr_en && full) && !(rd_en && empty));

endmodule

// File: rtl/tdc_control.sv
module tdc_control (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    pause,
  input  logic                    tdc_intb,
  input  logic                    spi_busy,
  input  logic                    fifo_full,
  input  lidar_pkg::shot_period_t shot_period,
  input  lidar_pkg::uart_byte_t   rx_byte,
  output logic                    start_signal,
  output logic                    shot_pulse,
  output logic                    byte_start,
  output logic                    last_byte,
  output logic                    wr_en,
  output lidar_pkg::uart_byte_t   tx_byte,
  output lidar_pkg::tdc_result_t  wr_data
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FIRE,
    S_WAIT_INT,
    S_SEND_CMD,
    S_READ_HI,
    S_READ_LO,
    S_PUSH
  } state_t;

  state_t                  state;
  lidar_pkg::shot_period_t period_cnt;
  lidar_pkg::uart_byte_t   result_hi;
  logic                    intb_meta;
  logic                    intb_sync;
  logic                    issued;
  logic                    in_xfer;
  logic                    byte_done;
  logic                    shot_ready;

  // SPI handshake shared by the three byte states
  assign in_xfer    = (state == S_SEND_CMD) || (state == S_READ_HI) || (state == S_READ_LO);
  assign byte_start = in_xfer && !issued && !spi_busy;
  assign byte_done  = in_xfer && issued && !spi_busy;
  // Dummy byte clocks the result out
  assign tx_byte    = (state == S_SEND_CMD) ? lidar_pkg::TDC_READ_CMD : 8'h00;
  assign last_byte  = (state == S_READ_LO);

  assign start_signal = (state == S_FIRE);
  assign shot_pulse   = (state == S_FIRE);
  assign wr_en        = (state == S_PUSH);

  // Full FIFO holds off the shot, so a result always has room
  assign shot_ready = enable && !pause && !fifo_full && (period_cnt >= shot_period);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      issued     <= 1'b0;
      period_cnt <= '1;
      intb_meta  <= 1'b1;
      intb_sync  <= 1'b1;
    end else begin
      // TDC interrupt comes from another clock domain
      intb_meta <= tdc_intb;
      intb_sync <= intb_meta;
      // Counts the fire cycle and the decision cycle ahead of it
      if (state == S_FIRE) begin
        period_cnt <= 16'd2;
      end else if (period_cnt != '1) begin
        period_cnt <= period_cnt + 16'd1;
      end
      if (byte_start) begin
        issued <= 1'b1;
      end else if (byte_done) begin
        issued <= 1'b0;
      end
      case (state)
        S_IDLE:     if (shot_ready) state <= S_FIRE;
        S_FIRE:     state <= S_WAIT_INT;
        // Interrupt is active low
        S_WAIT_INT: if (!intb_sync) state <= S_SEND_CMD;
        S_SEND_CMD: if (byte_done) state <= S_READ_HI;
        S_READ_HI:  if (byte_done) state <= S_READ_LO;
        S_READ_LO:  if (byte_done) state <= S_PUSH;
        S_PUSH:     state <= S_IDLE;
        default:    state <= S_IDLE;
      endcase
    end
  end

  // High byte arrives first
  always_ff @(posedge clk) begin
    if (byte_done && (state == S_READ_HI)) begin
      result_hi <= rx_byte;
    end
    if (byte_done && (state == S_READ_LO)) begin
      wr_data <= {result_hi, rx_byte};
    end
  end

endmodule

// File: rtl/tdc_spi_master.sv
module tdc_spi_master #(
  parameter int SPI_CLK_DIV = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  byte_start,
  input  logic                  last_byte,
  input  logic                  miso,
  input  lidar_pkg::uart_byte_t tx_byte,
  output lidar_pkg::uart_byte_t rx_byte,
  output logic                  busy,
  output logic                  sck,
  output logic                  mosi,
  output logic                  cs
);

  localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

  logic [DIV_W-1:0]      div_cnt;
  logic [3:0]            half_cnt;
  logic                  div_done;
  logic                  last_q;
  logic                  miso_q;
  lidar_pkg::uart_byte_t shreg;

  assign div_done = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
  // Outgoing bits leave at the top, sampled bits enter at the bottom
  assign mosi    = shreg[7];
  assign rx_byte = shreg;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      sck      <= 1'b0;
      cs       <= 1'b1;
      div_cnt  <= '0;
      half_cnt <= '0;
      last_q   <= 1'b0;
      miso_q   <= 1'b0;
      shreg    <= '0;
    end else if (!busy) begin
      if (byte_start) begin
        busy     <= 1'b1;
        cs       <= 1'b0;
        last_q   <= last_byte;
        shreg    <= tx_byte;
        div_cnt  <= '0;
        half_cnt <= '0;
      end
    end else if (div_done) begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + 4'd1;
      sck      <= ~sck;
      if (!half_cnt[0]) begin
        // Rising SCK, capture miso
        miso_q <= miso;
      end else begin
        // Falling SCK, next bit onto mosi
        shreg <= {shreg[6:0], miso_q};
      end
      // Sixteen half periods make one byte
      if (half_cnt == 4'd15) begin
        busy <= 1'b0;
        if (last_q) begin
          cs <= 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  // Controller never starts a byte over one in flight
  assert property (@(posedge clk) disable iff (rst) byte_start |-> !busy);

endmodule

// File: rtl/tdc_regs.sv
module tdc_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  lidar_pkg::wb_addr_t     wb_adr,
  input  lidar_pkg::wb_data_t     wb_dat_w,
  input  logic                    shot_pulse,
  output lidar_pkg::wb_data_t     wb_dat_r,
  output logic                    wb_ack,
  output logic                    enable,
  output logic                    pause,
  output lidar_pkg::shot_period_t shot_period
);

  lidar_pkg::wb_data_t shot_count;
  logic                access;

  // Fresh access only while no ack is out
  assign access = wb_cyc && wb_stb && !wb_ack;

  // Ack, control and period registers
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack      <= 1'b0;
      enable      <= 1'b0;
      pause       <= 1'b0;
      shot_period <= 16'd1000;
    end else begin
      wb_ack <= access;
      if (access && wb_we) begin
        case (wb_adr)
          lidar_pkg::REG_CTRL: begin
            enable <= wb_dat_w[0];
            pause  <= wb_dat_w[1];
          end
          lidar_pkg::REG_PERIOD: shot_period <= wb_dat_w;
          // Shot counter ignores writes
          default: ;
        endcase
      end
    end
  end

  // Counts every start pulse sent to the TDC
  always_ff @(posedge clk) begin
    if (rst) begin
      shot_count <= '0;
    end else if (shot_pulse) begin
      shot_count <= shot_count + 16'd1;
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (access) begin
      case (wb_adr)
        lidar_pkg::REG_CTRL:   wb_dat_r <= {14'd0, pause, enable};
        lidar_pkg::REG_PERIOD: wb_dat_r <= shot_period;
        lidar_pkg::REG_SHOTS:  wb_dat_r <= shot_count;
        default:               wb_dat_r <= '0;
      endcase
    end
  end

  // Single-cycle ack even with stb still held by the master
  assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

// File: rtl/lidar_pkg.sv
package lidar_pkg;

  // One time-of-flight result as read from the TDC
  typedef logic [15:0] tdc_result_t;

  // Byte on the SPI link or the UART line
  typedef logic [7:0] uart_byte_t;

  // Register block word address and data
  typedef logic [1:0] wb_addr_t;
  typedef logic [15:0] wb_data_t;

  // Clock cycles between two shots
  typedef logic [15:0] shot_period_t;

  // Register map
  // Control, bit 0 enable and bit 1 pause
  localparam wb_addr_t REG_CTRL = 2'd0;
  localparam wb_addr_t REG_PERIOD = 2'd1;
  // Shot counter, read only
  localparam wb_addr_t REG_SHOTS = 2'd2;

  // Opcode that reads the 16-bit time result from the TDC
  localparam uart_byte_t TDC_READ_CMD = 8'h10;

endpackage
